//--- filelist.f
+incdir+hw
hw/pipeCtrlPkg.sv
hw/fetchUnit.sv
hw/stageReg.sv
hw/hazardUnit.sv
hw/retireUnit.sv
hw/pipeCtrlTop.sv
test/pipeCtrlTb.sv

//--- run.sh
#!/bin/sh
# builds the pipeline control testbench with Verilator, runs it and
# decides the result from the printed pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module pipeCtrlTb -o simv || { echo "build failed"; exit 1; }
out=$(./obj_dir/simv 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***' && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- test/pipeCtrlTb.sv
`timescale 1ns/1ps
`include "pipeCtrl_defs.svh"

module pipeCtrlTb;
    import pipeCtrlPkg::*;

    localparam int NUM_RETIRE  = 300; // retirements before the run ends
    localparam int RET_TIMEOUT = 200; // cycles allowed between two retirements

    logic             clk;
    logic             arstN;
    logic [`PC_W-1:0] fetchPc;
    logic             instValid;
    instToken_t       instWord;
    logic             retValid;
    instToken_t       retTok;
    logic             retReady;

    logic [31:0]      rngState = 32'd94067;
    logic [`PC_W-1:0] modelPc; // next pc on the architectural path
    logic [7:0]       lastSeq;
    int               retiredCount;
    int               branchCount;
    int               excpCount;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program rules for the memory model and the reference path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshiftStep(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // every bit of the pc reaches the hash through the multiply
    function automatic logic [15:0] pcHash(input logic [`PC_W-1:0] pc);
        logic [15:0] h;
        h = pc * 16'd31421 + 16'd29;
        return h ^ (h >> 8);
    endfunction

    function automatic logic isBranchPc(input logic [`PC_W-1:0] pc);
        return (pcHash(pc) % 16'd7) == 16'd0;
    endfunction

    function automatic logic isExcpPc(input logic [`PC_W-1:0] pc);
        return !isBranchPc(pc) && ((pcHash(pc) % 16'd29) == 16'd0);
    endfunction

    function automatic logic [`PC_W-1:0] branchTarget(input logic [`PC_W-1:0] pc);
        return pcHash(pc) % 16'd64;
    endfunction

    // pc and seq stay zero, fetch fills them in
    function automatic instToken_t memWord(input logic [`PC_W-1:0] pc);
        instToken_t w;
        w          = '0;
        w.isBranch = isBranchPc(pc);
        w.isExcp   = isExcpPc(pc);
        if (w.isBranch) begin
            w.target = branchTarget(pc);
        end
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // error reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkEq(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        if (actual !== expected) begin
            failRun($sformatf("FAILED at %0t ns: %s, got %0h, expected %0h",
                              $time, what, actual, expected));
        end
    endtask

    // walks the architectural path up to the next pc that must retire
    task automatic compareWithModel(input instToken_t tok);
        int         hops;
        logic [7:0] seqStep;
        hops = 0;
        while (isExcpPc(modelPc)) begin
            excpCount++; // excepting pc is skipped, fetch restarts at the vector
            modelPc = `EXCP_VEC;
            hops++;
            if (hops > 4) begin
                failRun("reference path is stuck in a loop of exceptions");
            end
        end
        checkEq(64'(tok.pc), 64'(modelPc), "retired pc");
        checkEq(64'(tok.isBranch), 64'(isBranchPc(modelPc)), "branch flag of retired token");
        checkEq(64'(tok.isExcp), 64'd0, "exception flag of retired token");
        if (tok.isBranch) begin
            checkEq(64'(tok.target), 64'(branchTarget(modelPc)), "branch target");
        end
        // fetch order rises; up to two wrong-path tokens behind a branch and
        // three behind an exception may be dropped between two retirements
        if (retiredCount > 0) begin
            seqStep = tok.seq - lastSeq;
            checkEq(64'((seqStep >= 8'd1) && (seqStep <= 8'd6)), 64'd1, "sequence step");
        end
        lastSeq = tok.seq;
        if (isBranchPc(modelPc)) begin
            branchCount++;
            modelPc = branchTarget(modelPc);
        end else begin
            modelPc = modelPc + 16'd1;
        end
        retiredCount++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // DUT and environment
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    pipeCtrlTop pipeCtrlTop_i (
        .clk       (clk),
        .arstN     (arstN),
        .fetchPc   (fetchPc),
        .instValid (instValid),
        .instWord  (instWord),
        .retValid  (retValid),
        .retTok    (retTok),
        .retReady  (retReady)
    );

    assign instWord = memWord(fetchPc); // instruction port answers in the same cycle

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // instruction wait one cycle in four, back-pressure one cycle in three
    initial begin : stimulus
        instValid <= 1'b0;
        retReady  <= 1'b0;
        forever begin
            @(posedge clk);
            rngState = xorshiftStep(rngState);
            instValid <= (rngState % 32'd4) != 32'd0;
            rngState = xorshiftStep(rngState);
            retReady  <= (rngState % 32'd3) != 32'd0;
        end
    end

    initial begin : mainFlow
        int         edges;
        int         idle;
        logic       blockedLast;
        instToken_t heldTok;
        arstN        <= 1'b0;
        modelPc      = '0;
        lastSeq      = '0;
        retiredCount = 0;
        branchCount  = 0;
        excpCount    = 0;
        edges        = 0;
        idle         = 0;
        blockedLast  = 1'b0;
        heldTok      = '0;

        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            checkEq(64'(retValid), 64'd0, "retValid during reset");
            checkEq(64'(fetchPc), 64'd0, "fetchPc during reset");
        end
        @(posedge clk);
        arstN <= 1'b1;

        // outputs are sampled on the falling edge, halfway between updates
        while (retiredCount < NUM_RETIRE) begin
            @(negedge clk);
            if (edges < 4) begin
                checkEq(64'(retValid), 64'd0, "retValid before a token could pass four stages");
            end
            if (blockedLast) begin
                checkEq(64'(retValid), 64'd1, "retValid dropped under back-pressure");
                checkEq(64'(retTok), 64'(heldTok), "retTok changed under back-pressure");
            end
            if (retValid && retReady) begin
                compareWithModel(retTok);
                idle = 0;
            end else begin
                idle++;
                if (idle > RET_TIMEOUT) begin
                    failRun($sformatf("timeout: no token retired for %0d cycles", RET_TIMEOUT));
                end
            end
            blockedLast = retValid && !retReady;
            heldTok     = retTok;
            edges++;
        end

        $display("retired %0d tokens, %0d branches, %0d exceptions skipped",
                 retiredCount, branchCount, excpCount);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- hw/pipeCtrlTop.sv
`timescale 1ns/1ps
`include "pipeCtrl_defs.svh"

module pipeCtrlTop (
    input  logic                    clk,
    input  logic                    arstN,
    output logic [`PC_W-1:0]        fetchPc,
    input  logic                    instValid,
    input  pipeCtrlPkg::instToken_t instWord,
    output logic                    retValid,
    output pipeCtrlPkg::instToken_t retTok,
    input  logic                    retReady
);
    import pipeCtrlPkg::*;

    logic [`NUM_STAGES:0]        stgValid; // index 0 is the fetch output
    instToken_t                  stgTok [`NUM_STAGES+1];
    stageCtl_t [`NUM_STAGES-1:0] stageCtl;
    stageCtl_t                   retireCtl;
    redirect_t                   redirect;
    instToken_t                  memTok;
    logic                        fetchStall;
    logic                        dWait;
    logic                        branchM;
    logic                        excpM;

    // memory stage is the last register of the loop
    assign memTok  = stgTok[`NUM_STAGES];
    assign branchM = stgValid[`NUM_STAGES] & memTok.isBranch;
    assign excpM   = stgValid[`NUM_STAGES] & memTok.isExcp;

    fetchUnit fetchUnit_i (
        .clk        (clk),
        .arstN      (arstN),
        .fetchPc    (fetchPc),
        .instValid  (instValid),
        .instWord   (instWord),
        .fetchStall (fetchStall),
        .redirect   (redirect),
        .fetchValid (stgValid[0]),
        .fetchTok   (stgTok[0])
    );

    // decode, execute and memory
    for (genvar k = 0; k < `NUM_STAGES; k++) begin : gStage
        stageReg #(
            .payloadT (instToken_t)
        ) stageReg_i (
            .clk      (clk),
            .arstN    (arstN),
            .ctl      (stageCtl[k]),
            .inValid  (stgValid[k]),
            .inData   (stgTok[k]),
            .outValid (stgValid[k+1]),
            .outData  (stgTok[k+1])
        );
    end

    hazardUnit hazardUnit_i (
        .clk        (clk),
        .arstN      (arstN),
        .instValid  (instValid),
        .dWait      (dWait),
        .branchM    (branchM),
        .excpM      (excpM),
        .memTok     (memTok),
        .stageCtl   (stageCtl),
        .fetchStall (fetchStall),
        .retireCtl  (retireCtl),
        .redirect   (redirect)
    );

    retireUnit retireUnit_i (
        .clk      (clk),
        .arstN    (arstN),
        .ctl      (retireCtl),
        .inValid  (stgValid[`NUM_STAGES]),
        .inTok    (memTok),
        .retValid (retValid),
        .retTok   (retTok),
        .retReady (retReady),
        .dWait    (dWait)
    );

endmodule

//--- hw/retireUnit.sv
`timescale 1ns/1ps

module retireUnit (
    input  logic                    clk,
    input  logic                    arstN,
    input  pipeCtrlPkg::stageCtl_t  ctl,
    input  logic                    inValid,
    input  pipeCtrlPkg::instToken_t inTok,
    output logic                    retValid,
    output pipeCtrlPkg::instToken_t retTok,
    input  logic                    retReady,
    output logic                    dWait
);

    // a held token the environment will not take blocks the whole pipe
    assign dWait = retValid & ~retReady;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // when not stalled the slot is either empty or being handed off,
    // so it always takes whatever memory offers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            retValid <= 1'b0;
        end else if (!ctl.stall) begin
            retValid <= inValid & ~ctl.flush; // an exception leaves a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (!ctl.stall && !ctl.flush && inValid) begin
            retTok <= inTok;
        end
    end

    // the hazard unit must freeze retire while the output is blocked,
    // otherwise the presented token would change under the environment
    retireHeldUnderWait: assert property (
        @(posedge clk) disable iff (!arstN)
        dWait |-> ctl.stall ##1 (retValid && $stable(retTok))
    ) else $error("retired token changed during back-pressure");

endmodule

//--- hw/hazardUnit.sv
`timescale 1ns/1ps
`include "pipeCtrl_defs.svh"

module hazardUnit (
    input  logic                                       clk,
    input  logic                                       arstN,
    input  logic                                       instValid,
    input  logic                                       dWait,
    input  logic                                       branchM,
    input  logic                                       excpM,
    input  pipeCtrlPkg::instToken_t                    memTok,
    output pipeCtrlPkg::stageCtl_t [`NUM_STAGES-1:0] stageCtl,
    output logic                                       fetchStall,
    output pipeCtrlPkg::stageCtl_t                     retireCtl,
    output pipeCtrlPkg::redirect_t                     redirect
);
    import pipeCtrlPkg::*;

    localparam stageCtl_t STALL_CTL = '{stall: 1'b1, flush: 1'b0};
    localparam stageCtl_t FLUSH_CTL = '{stall: 1'b0, flush: 1'b1};

    logic redirectSeen; // a redirect went out last cycle

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // priority chain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        stageCtl   = '0;
        retireCtl  = '0;
        fetchStall = 1'b0;
        redirect   = '0;
        if (dWait) begin
            // retire is blocked so nothing may move, redirects wait in memory
            stageCtl   = {`NUM_STAGES{STALL_CTL}};
            retireCtl  = STALL_CTL;
            fetchStall = 1'b1;
        end else if (excpM) begin
            // every register loads a bubble, the excepting token included
            stageCtl  = {`NUM_STAGES{FLUSH_CTL}};
            retireCtl = FLUSH_CTL;
            redirect  = '{valid: 1'b1, pc: `EXCP_VEC};
        end else if (branchM) begin
            // decode and execute hold wrong-path tokens, so the registers
            // behind them load bubbles while the branch itself moves to retire
            stageCtl = {`NUM_STAGES{FLUSH_CTL}};
            redirect = '{valid: 1'b1, pc: memTok.target};
        end else if (!instValid) begin
            stageCtl[0] = FLUSH_CTL; // decode takes a bubble
            fetchStall  = 1'b1;      // pc stays put until the port answers
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            redirectSeen <= 1'b0;
        end else begin
            redirectSeen <= redirect.valid;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // after a redirect the memory stage holds a bubble, so no second one follows
    noBackToBackRedirect: assert property (
        @(posedge clk) disable iff (!arstN)
        redirect.valid |-> !redirectSeen
    ) else $error("redirect on two consecutive cycles");

    // a redirect seen under back-pressure stays pending in memory
    deferredRedirect: assert property (
        @(posedge clk) disable iff (!arstN)
        dWait && (branchM || excpM) |-> !redirect.valid ##1 (branchM || excpM)
    ) else $error("redirect lost or taken during data wait");

endmodule

//--- hw/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  pipeCtrlPkg::stageCtl_t ctl,
    input  logic                   inValid,
    input  payloadT                inData,
    output logic                   outValid,
    output payloadT                outData
);

    // the valid bit is the only control state of a stage
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (ctl.stall) begin
            outValid <= outValid; // frozen with its payload
        end else if (ctl.flush) begin
            outValid <= 1'b0; // bubble
        end else begin
            outValid <= inValid;
        end
    end

    // payload only moves when a real token comes in
    always_ff @(posedge clk) begin
        if (!ctl.stall && !ctl.flush && inValid) begin
            outData <= inData;
        end
    end

    // the hazard unit picks exactly one action per stage
    stallFlushExclusive: assert property (
        @(posedge clk) disable iff (!arstN)
        !(ctl.stall && ctl.flush)
    ) else $error("stage got stall and flush together");

endmodule

//--- hw/fetchUnit.sv
`timescale 1ns/1ps
`include "pipeCtrl_defs.svh"

module fetchUnit (
    input  logic                    clk,
    input  logic                    arstN,
    output logic [`PC_W-1:0]        fetchPc,
    input  logic                    instValid,
    input  pipeCtrlPkg::instToken_t instWord,
    input  logic                    fetchStall,
    input  pipeCtrlPkg::redirect_t  redirect,
    output logic                    fetchValid,
    output pipeCtrlPkg::instToken_t fetchTok
);

    logic [`PC_W-1:0] pcReg;
    logic [7:0]       seqCnt;

    // the instruction port answers combinationally on this pc
    assign fetchPc = pcReg;

    // a token leaves fetch only when the port has one and nothing holds us
    assign fetchValid = instValid & ~fetchStall;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // token forming
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        fetchTok     = instWord; // branch and exception flags come from memory
        fetchTok.pc  = pcReg;
        fetchTok.seq = seqCnt;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pc and sequence counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcReg  <= '0;
            seqCnt <= '0;
        end else if (redirect.valid) begin
            // the token fetched this cycle is wrong path and gets flushed,
            // so its sequence number is handed to the first target token
            pcReg <= redirect.pc;
        end else if (fetchValid) begin
            pcReg  <= pcReg + 1'b1;
            seqCnt <= seqCnt + 1'b1;
        end
    end

endmodule

//--- hw/pipeCtrlPkg.sv
`include "pipeCtrl_defs.svh"

package pipeCtrlPkg;

    // one instruction as it travels down the pipe
    typedef struct packed {
        logic [`PC_W-1:0] pc;       // filled in by fetch
        logic             isBranch; // taken branch, resolved in memory
        logic             isExcp;   // raises an exception in memory
        logic [`PC_W-1:0] target;   // branch destination
        logic [7:0]       seq;      // fetch order number, filled in by fetch
    } instToken_t;

    // per-stage command from the hazard unit
    typedef struct packed {
        logic stall; // hold valid and payload
        logic flush; // load a bubble
    } stageCtl_t;

    // new fetch pc, applied on the next edge
    typedef struct packed {
        logic             valid;
        logic [`PC_W-1:0] pc;
    } redirect_t;

endpackage

//--- hw/pipeCtrl_defs.svh
`ifndef PIPE_CTRL_DEFS_SVH
`define PIPE_CTRL_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// width of every program counter in the slice
`define PC_W 16

// stage registers between fetch and retire
// index 0 is decode, 1 is execute and the last one is memory
`define NUM_STAGES 3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// redirect targets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define EXCP_VEC 16'h0100 // fetch restarts here after an exception

`endif
